// ==== rtl/pulp_soc_pkg.sv ====
/*
 * Shared constants, enums and the atomic ALU of the reduced SoC tile.
 * Both address windows must stay aligned to their own size.
 */
`default_nettype none

package pulp_soc_pkg;

  // datapath widths
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned ID_W       = 4;
  localparam int unsigned N_CLUSTERS = 4;

  // L2 window
  localparam logic [ADDR_W-1:0] L2_BASE  = 32'h1C00_0000;
  localparam int unsigned       L2_WORDS = 256;
  localparam int unsigned       L2_IDX_W = 8;
  localparam int unsigned       L2_BYTES = L2_WORDS * 4;

  // cluster control peripheral window
  localparam logic [ADDR_W-1:0] PERIPH_BASE  = 32'h1A10_0000;
  localparam int unsigned       PERIPH_SPAN  = 16;
  localparam int unsigned       PERIPH_OFF_W = $clog2(PERIPH_SPAN);

  // peripheral register offsets
  localparam logic [PERIPH_OFF_W-1:0] REG_FETCH_EN = 'h0;
  localparam logic [PERIPH_OFF_W-1:0] REG_EOC      = 'h4;
  localparam logic [PERIPH_OFF_W-1:0] REG_BUSY     = 'h8;

  typedef enum logic [2:0] {
    OP_LOAD  = 3'd0,
    OP_STORE = 3'd1,
    OP_SWAP  = 3'd2,
    OP_ADD   = 3'd3,
    OP_AND   = 3'd4,
    OP_OR    = 3'd5,
    OP_MAX   = 3'd6,
    OP_MIN   = 3'd7
  } amo_op_e;

  typedef enum logic [1:0] {
    RGN_L2     = 2'd0,
    RGN_PERIPH = 2'd1,
    RGN_NONE   = 2'd2
  } region_e;

  // new word of a read-modify-write, loads keep the old word
  function automatic logic [DATA_W-1:0] amo_apply(
    input amo_op_e           op,
    input logic [DATA_W-1:0] old_word,
    input logic [DATA_W-1:0] operand
  );
    logic [DATA_W-1:0] result;
    case (op)
      OP_LOAD:           result = old_word;
      OP_STORE, OP_SWAP: result = operand;
      OP_ADD:            result = old_word + operand;
      OP_AND:            result = old_word & operand;
      OP_OR:             result = old_word | operand;
      // signed compare as in RISC-V amomax.w / amomin.w
      OP_MAX:  result = ($signed(old_word) > $signed(operand)) ? old_word : operand;
      OP_MIN:  result = ($signed(old_word) < $signed(operand)) ? old_word : operand;
      default: result = old_word;
    endcase
    return result;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/soc_addr_decode.sv ====
/*
 * Decode stage, one request per cycle with no stall.
 * Unaligned, unmapped and illegal peripheral accesses leave as RGN_NONE.
 */
`timescale 1ns/1ps
`default_nettype none

module soc_addr_decode (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  req_i,
  input  pulp_soc_pkg::amo_op_e                 req_op_i,
  input  logic [pulp_soc_pkg::ADDR_W-1:0]       req_addr_i,
  input  logic [pulp_soc_pkg::DATA_W-1:0]       req_wdata_i,
  input  logic [pulp_soc_pkg::ID_W-1:0]         req_id_i,
  output logic                                  dec_valid_o,
  output pulp_soc_pkg::region_e                 dec_region_o,
  output logic [pulp_soc_pkg::L2_IDX_W-1:0]     dec_l2_idx_o,
  output logic [pulp_soc_pkg::PERIPH_OFF_W-1:0] dec_periph_off_o,
  output pulp_soc_pkg::amo_op_e                 dec_op_o,
  output logic [pulp_soc_pkg::DATA_W-1:0]       dec_wdata_o,
  output logic [pulp_soc_pkg::ID_W-1:0]         dec_id_o
);
  import pulp_soc_pkg::*;

  logic [ADDR_W-1:0]       l2_off;
  logic [ADDR_W-1:0]       periph_off;
  logic [PERIPH_OFF_W-1:0] reg_off;
  logic                    misaligned;
  logic                    l2_hit;
  logic                    periph_hit;
  logic                    known_reg;
  logic                    status_reg;
  region_e                 region_d;

  assign l2_off     = req_addr_i - L2_BASE;
  assign periph_off = req_addr_i - PERIPH_BASE;
  assign reg_off    = periph_off[PERIPH_OFF_W-1:0];
  assign misaligned = |req_addr_i[1:0];

  assign l2_hit     = (req_addr_i >= L2_BASE) && (l2_off < L2_BYTES);
  assign periph_hit = (req_addr_i >= PERIPH_BASE) && (periph_off < PERIPH_SPAN);

  // offset 0xc is inside the window but has no register
  assign status_reg = (reg_off == REG_EOC) || (reg_off == REG_BUSY);
  assign known_reg  = (reg_off == REG_FETCH_EN) || status_reg;

  always_comb begin
    region_d = RGN_NONE;
    if (!misaligned) begin
      if (l2_hit) begin
        region_d = RGN_L2;
      end else if (periph_hit && known_reg && !(status_reg && req_op_i != OP_LOAD)) begin
        // status registers only take loads
        region_d = RGN_PERIPH;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      dec_region_o     <= region_d;
      dec_l2_idx_o     <= l2_off[L2_IDX_W+1:2];
      dec_periph_off_o <= reg_off;
      dec_op_o         <= req_op_i;
      dec_wdata_o      <= req_wdata_i;
      dec_id_o         <= req_id_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/l2_atomics_exec.sv ====
/*
 * L2 word memory with single-cycle atomic read-modify-write.
 * Old word is read combinationally, new word lands at the end of execute.
 */
`timescale 1ns/1ps
`default_nettype none

module l2_atomics_exec (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              dec_valid_i,
  input  pulp_soc_pkg::region_e             dec_region_i,
  input  logic [pulp_soc_pkg::L2_IDX_W-1:0] dec_l2_idx_i,
  input  pulp_soc_pkg::amo_op_e             dec_op_i,
  input  logic [pulp_soc_pkg::DATA_W-1:0]   dec_wdata_i,
  output logic [pulp_soc_pkg::DATA_W-1:0]   l2_rdata_o
);
  import pulp_soc_pkg::*;

  logic [DATA_W-1:0] mem_q [L2_WORDS];
  logic [DATA_W-1:0] old_word;
  logic [DATA_W-1:0] new_word;
  logic              l2_sel;
  logic              mem_we;

  assign l2_sel = dec_valid_i && (dec_region_i == RGN_L2);

  // read port
  assign old_word   = mem_q[dec_l2_idx_i];
  assign l2_rdata_o = old_word;

  // atomic alu
  assign new_word = amo_apply(dec_op_i, old_word, dec_wdata_i);

  // loads never write back
  assign mem_we = l2_sel && (dec_op_i != OP_LOAD);

  // read and write share the execute cycle, so each atomic is indivisible
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < L2_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (mem_we) begin
      mem_q[dec_l2_idx_i] <= new_word;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cluster_ctrl_periph.sv ====
/*
 * Cluster control registers: fetch-enable mask plus live eoc and busy.
 * Atomics on the mask use the L2 rules on its zero-extended value.
 */
`timescale 1ns/1ps
`default_nettype none

module cluster_ctrl_periph (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  dec_valid_i,
  input  pulp_soc_pkg::region_e                 dec_region_i,
  input  logic [pulp_soc_pkg::PERIPH_OFF_W-1:0] dec_periph_off_i,
  input  pulp_soc_pkg::amo_op_e                 dec_op_i,
  input  logic [pulp_soc_pkg::DATA_W-1:0]       dec_wdata_i,
  input  logic [pulp_soc_pkg::N_CLUSTERS-1:0]   cl_eoc_i,
  input  logic [pulp_soc_pkg::N_CLUSTERS-1:0]   cl_busy_i,
  output logic [pulp_soc_pkg::DATA_W-1:0]       periph_rdata_o,
  output logic [pulp_soc_pkg::N_CLUSTERS-1:0]   cl_fetch_en_o
);
  import pulp_soc_pkg::*;

  localparam int unsigned PAD_W = DATA_W - N_CLUSTERS;

  logic [N_CLUSTERS-1:0] fetch_en_q;
  logic [DATA_W-1:0]     mask_word;
  logic [DATA_W-1:0]     new_word;
  logic                  fetch_en_we;

  assign mask_word = {{PAD_W{1'b0}}, fetch_en_q};
  assign new_word  = amo_apply(dec_op_i, mask_word, dec_wdata_i);

  // decode already rejected writes to the status registers
  assign fetch_en_we = dec_valid_i && (dec_region_i == RGN_PERIPH) &&
                       (dec_periph_off_i == REG_FETCH_EN) && (dec_op_i != OP_LOAD);

  always_comb begin
    case (dec_periph_off_i)
      REG_FETCH_EN: periph_rdata_o = mask_word;
      REG_EOC:      periph_rdata_o = {{PAD_W{1'b0}}, cl_eoc_i};
      REG_BUSY:     periph_rdata_o = {{PAD_W{1'b0}}, cl_busy_i};
      default:      periph_rdata_o = '0;
    endcase
  end

  // only the low bits of the written word are kept
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fetch_en_q <= '0;
    end else if (fetch_en_we) begin
      fetch_en_q <= new_word[N_CLUSTERS-1:0];
    end
  end

  assign cl_fetch_en_o = fetch_en_q;

endmodule

`default_nettype wire

// ==== rtl/soc_resp_merge.sv ====
/*
 * Result stage, registers one response per cycle.
 * Responses cannot be stalled and must be taken when valid.
 */
`timescale 1ns/1ps
`default_nettype none

module soc_resp_merge (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            dec_valid_i,
  input  pulp_soc_pkg::region_e           dec_region_i,
  input  pulp_soc_pkg::amo_op_e           dec_op_i,
  input  logic [pulp_soc_pkg::ID_W-1:0]   dec_id_i,
  input  logic [pulp_soc_pkg::DATA_W-1:0] l2_rdata_i,
  input  logic [pulp_soc_pkg::DATA_W-1:0] periph_rdata_i,
  output logic                            resp_valid_o,
  output logic [pulp_soc_pkg::DATA_W-1:0] resp_rdata_o,
  output logic [pulp_soc_pkg::ID_W-1:0]   resp_id_o,
  output logic                            resp_err_o
);
  import pulp_soc_pkg::*;

  logic [DATA_W-1:0] rdata_d;

  always_comb begin
    case (dec_region_i)
      RGN_L2:     rdata_d = l2_rdata_i;
      RGN_PERIPH: rdata_d = periph_rdata_i;
      default:    rdata_d = '0;
    endcase
    // stores return no data
    if (dec_op_i == OP_STORE) begin
      rdata_d = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_o <= 1'b0;
      resp_err_o   <= 1'b0;
    end else begin
      resp_valid_o <= dec_valid_i;
      resp_err_o   <= dec_valid_i && (dec_region_i == RGN_NONE);
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      resp_rdata_o <= rdata_d;
      resp_id_o    <= dec_id_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pulp_soc.sv ====
/*
 * Reduced SoC tile: decode, execute and result stages, two items in flight.
 * Every request gets its response exactly two cycles later.
 */
`timescale 1ns/1ps
`default_nettype none

module pulp_soc (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                req_i,
  input  pulp_soc_pkg::amo_op_e               req_op_i,
  input  logic [pulp_soc_pkg::ADDR_W-1:0]     req_addr_i,
  input  logic [pulp_soc_pkg::DATA_W-1:0]     req_wdata_i,
  input  logic [pulp_soc_pkg::ID_W-1:0]       req_id_i,
  input  logic [pulp_soc_pkg::N_CLUSTERS-1:0] cl_eoc_i,
  input  logic [pulp_soc_pkg::N_CLUSTERS-1:0] cl_busy_i,
  output logic                                resp_valid_o,
  output logic [pulp_soc_pkg::DATA_W-1:0]     resp_rdata_o,
  output logic [pulp_soc_pkg::ID_W-1:0]       resp_id_o,
  output logic                                resp_err_o,
  output logic [pulp_soc_pkg::N_CLUSTERS-1:0] cl_fetch_en_o
);
  import pulp_soc_pkg::*;

  // decoded request
  logic                    dec_valid;
  region_e                 dec_region;
  logic [L2_IDX_W-1:0]     dec_l2_idx;
  logic [PERIPH_OFF_W-1:0] dec_periph_off;
  amo_op_e                 dec_op;
  logic [DATA_W-1:0]       dec_wdata;
  logic [ID_W-1:0]         dec_id;

  // execute read data
  logic [DATA_W-1:0]       l2_rdata;
  logic [DATA_W-1:0]       periph_rdata;

  soc_addr_decode i_addr_decode (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .req_i            (req_i),
    .req_op_i         (req_op_i),
    .req_addr_i       (req_addr_i),
    .req_wdata_i      (req_wdata_i),
    .req_id_i         (req_id_i),
    .dec_valid_o      (dec_valid),
    .dec_region_o     (dec_region),
    .dec_l2_idx_o     (dec_l2_idx),
    .dec_periph_off_o (dec_periph_off),
    .dec_op_o         (dec_op),
    .dec_wdata_o      (dec_wdata),
    .dec_id_o         (dec_id)
  );

  l2_atomics_exec i_l2_atomics (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .dec_valid_i  (dec_valid),
    .dec_region_i (dec_region),
    .dec_l2_idx_i (dec_l2_idx),
    .dec_op_i     (dec_op),
    .dec_wdata_i  (dec_wdata),
    .l2_rdata_o   (l2_rdata)
  );

  cluster_ctrl_periph i_cluster_ctrl (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .dec_valid_i      (dec_valid),
    .dec_region_i     (dec_region),
    .dec_periph_off_i (dec_periph_off),
    .dec_op_i         (dec_op),
    .dec_wdata_i      (dec_wdata),
    .cl_eoc_i         (cl_eoc_i),
    .cl_busy_i        (cl_busy_i),
    .periph_rdata_o   (periph_rdata),
    .cl_fetch_en_o    (cl_fetch_en_o)
  );

  soc_resp_merge i_resp_merge (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .dec_valid_i    (dec_valid),
    .dec_region_i   (dec_region),
    .dec_op_i       (dec_op),
    .dec_id_i       (dec_id),
    .l2_rdata_i     (l2_rdata),
    .periph_rdata_i (periph_rdata),
    .resp_valid_o   (resp_valid_o),
    .resp_rdata_o   (resp_rdata_o),
    .resp_id_o      (resp_id_o),
    .resp_err_o     (resp_err_o)
  );

endmodule

`default_nettype wire

// ==== verification/pulp_soc_sva.sv ====
/*
 * Bound to pulp_soc, checks the fixed two-cycle response timing and reset state.
 * Timing checks start once two cycles without reset have passed.
 */
`timescale 1ns/1ps
`default_nettype none

module pulp_soc_sva (
  input logic                                clk_i,
  input logic                                rst_i,
  input logic                                req_i,
  input logic [pulp_soc_pkg::ID_W-1:0]       req_id_i,
  input logic                                resp_valid_o,
  input logic [pulp_soc_pkg::ID_W-1:0]       resp_id_o,
  input logic                                resp_err_o,
  input logic [pulp_soc_pkg::N_CLUSTERS-1:0] cl_fetch_en_o
);

  // one response per request, two edges later
  a_resp_timing: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (!$past(rst_i) && !$past(rst_i, 2)) |-> (resp_valid_o == $past(req_i, 2))
  ) else $error("resp_valid_o does not follow req_i by two cycles");

  a_resp_id: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (resp_valid_o && !$past(rst_i) && !$past(rst_i, 2)) |-> (resp_id_o == $past(req_id_i, 2))
  ) else $error("resp_id_o differs from the request id two cycles earlier");

  // outputs inactive through reset and in the cycle after
  a_reset_quiet: assert property (
    @(posedge clk_i)
    rst_i |=> (!resp_valid_o && (cl_fetch_en_o == '0))
  ) else $error("resp_valid_o or cl_fetch_en_o active during or after reset");

  a_err_needs_valid: assert property (
    @(posedge clk_i) disable iff (rst_i)
    resp_err_o |-> resp_valid_o
  ) else $error("resp_err_o high without resp_valid_o");

endmodule

bind pulp_soc pulp_soc_sva i_sva (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .req_i         (req_i),
  .req_id_i      (req_id_i),
  .resp_valid_o  (resp_valid_o),
  .resp_id_o     (resp_id_o),
  .resp_err_o    (resp_err_o),
  .cl_fetch_en_o (cl_fetch_en_o)
);

`default_nettype wire

// ==== verification/tb_pulp_soc.sv ====
/*
 * Testbench for pulp_soc with a shadow L2 and fetch mask, checked in request order.
 * cl_eoc_i and cl_busy_i are held stable while requests are in flight.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_pulp_soc;
  import pulp_soc_pkg::*;

  localparam int unsigned DRAIN_LIMIT = 40;

  typedef struct packed {
    logic [DATA_W-1:0]     rdata;
    logic [ID_W-1:0]       id;
    logic                  err;
    logic [N_CLUSTERS-1:0] mask;
  } resp_t;

  logic                  clk_i;
  logic                  rst_i;
  logic                  req_i;
  amo_op_e               req_op_i;
  logic [ADDR_W-1:0]     req_addr_i;
  logic [DATA_W-1:0]     req_wdata_i;
  logic [ID_W-1:0]       req_id_i;
  logic [N_CLUSTERS-1:0] cl_eoc_i;
  logic [N_CLUSTERS-1:0] cl_busy_i;
  logic                  resp_valid_o;
  logic [DATA_W-1:0]     resp_rdata_o;
  logic [ID_W-1:0]       resp_id_o;
  logic                  resp_err_o;
  logic [N_CLUSTERS-1:0] cl_fetch_en_o;

  // shadow state, updated in request order
  logic [DATA_W-1:0]     shadow_l2 [L2_WORDS];
  logic [N_CLUSTERS-1:0] shadow_mask;
  logic [ID_W-1:0]       next_id;
  resp_t                 exp_q [$];
  resp_t                 exp_resp;
  logic [L2_IDX_W-1:0]   word_sel [8];
  int unsigned           seed_ret;
  int unsigned           drain_cycles;

  pulp_soc dut (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [DATA_W-1:0] expected_new_word(input amo_op_e op,
      input logic [DATA_W-1:0] old_word, input logic [DATA_W-1:0] operand);
    int signed old_s;
    int signed opd_s;
    old_s = old_word;
    opd_s = operand;
    case (op)
      OP_STORE, OP_SWAP: return operand;
      OP_ADD:            return old_word + operand;
      OP_AND:            return old_word & operand;
      OP_OR:             return old_word | operand;
      OP_MAX:            return (old_s > opd_s) ? old_word : operand;
      OP_MIN:            return (old_s < opd_s) ? old_word : operand;
      default:           return old_word;
    endcase
  endfunction

  function automatic logic [ADDR_W-1:0] l2_addr(input logic [L2_IDX_W-1:0] idx);
    return L2_BASE + {idx, 2'b00};
  endfunction

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [DATA_W-1:0] expected,
                                 input logic [DATA_W-1:0] actual);
    $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
    abort_run();
  endtask

  // predicts the response from the shadow state, then drives the request
  task automatic issue(input amo_op_e op, input logic [ADDR_W-1:0] addr,
                       input logic [DATA_W-1:0] wdata);
    logic [ADDR_W-1:0] off;
    logic [DATA_W-1:0] old_word;
    logic [DATA_W-1:0] new_word;
    resp_t             exp;
    exp      = '0;
    exp.id   = next_id;
    exp.err  = 1'b1;
    off  = addr - L2_BASE;
    if (addr[1:0] == 2'b00 && addr >= L2_BASE && off < L2_WORDS * 4) begin
      old_word  = shadow_l2[off >> 2];
      exp.err   = 1'b0;
      exp.rdata = old_word;
      if (op != OP_LOAD) begin
        shadow_l2[off >> 2] = expected_new_word(op, old_word, wdata);
      end
    end else if (addr[1:0] == 2'b00 && addr >= PERIPH_BASE &&
                 addr - PERIPH_BASE < PERIPH_SPAN) begin
      off = addr - PERIPH_BASE;
      if (off == 0) begin
        old_word  = {{(DATA_W-N_CLUSTERS){1'b0}}, shadow_mask};
        exp.err   = 1'b0;
        exp.rdata = old_word;
        if (op != OP_LOAD) begin
          new_word    = expected_new_word(op, old_word, wdata);
          shadow_mask = new_word[N_CLUSTERS-1:0];
        end
      end else if (op == OP_LOAD && (off == 4 || off == 8)) begin
        exp.err   = 1'b0;
        exp.rdata = {{(DATA_W-N_CLUSTERS){1'b0}}, (off == 4) ? cl_eoc_i : cl_busy_i};
      end
    end
    if (exp.err || op == OP_STORE) begin
      exp.rdata = '0;
    end
    exp.mask = shadow_mask;
    exp_q.push_back(exp);
    @(posedge clk_i);
    req_i       <= 1'b1;
    req_op_i    <= op;
    req_addr_i  <= addr;
    req_wdata_i <= wdata;
    req_id_i    <= next_id;
    next_id     = next_id + 1'b1;
  endtask

  task automatic idle(input int unsigned cycles);
    repeat (cycles) begin
      @(posedge clk_i);
      req_i <= 1'b0;
    end
  endtask

  // store a start value, run the atomic, read back in the very next cycle
  task automatic check_atomic(input amo_op_e op, input logic [L2_IDX_W-1:0] idx,
                              input logic [DATA_W-1:0] init, input logic [DATA_W-1:0] operand);
    issue(OP_STORE, l2_addr(idx), init);
    issue(op, l2_addr(idx), operand);
    issue(OP_LOAD, l2_addr(idx), '0);
  endtask

  // outputs are sampled mid-cycle, away from the driving edge
  always @(negedge clk_i) begin
    if (!rst_i && resp_valid_o === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("response with id %0h arrived with no request outstanding", resp_id_o);
        abort_run();
      end else begin
        exp_resp = exp_q.pop_front();
        assert (resp_id_o === exp_resp.id)
          else report_mismatch("resp_id_o", exp_resp.id, resp_id_o);
        assert (resp_err_o === exp_resp.err)
          else report_mismatch("resp_err_o", exp_resp.err, resp_err_o);
        assert (resp_rdata_o === exp_resp.rdata)
          else report_mismatch("resp_rdata_o", exp_resp.rdata, resp_rdata_o);
        assert (cl_fetch_en_o === exp_resp.mask)
          else report_mismatch("cl_fetch_en_o", exp_resp.mask, cl_fetch_en_o);
      end
    end
  end

  initial begin
    seed_ret    = $urandom(16821);
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    req_i       = 1'b0;
    req_op_i    = OP_LOAD;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_id_i    = '0;
    cl_eoc_i    = '0;
    cl_busy_i   = '0;
    shadow_mask = '0;
    next_id     = '0;
    for (int i = 0; i < L2_WORDS; i++) begin
      shadow_l2[i] = '0;
    end
    repeat (4) @(posedge clk_i);
    rst_i     <= 1'b0;
    cl_eoc_i  <= N_CLUSTERS'($urandom);
    cl_busy_i <= N_CLUSTERS'($urandom);
    idle(2);

    // L2 must read zero after reset
    issue(OP_LOAD, l2_addr(8'hFF), '0);
    for (int i = 0; i < 8; i++) begin
      word_sel[i] = L2_IDX_W'($urandom);
      issue(OP_STORE, l2_addr(word_sel[i]), $urandom);
    end
    for (int i = 0; i < 8; i++) begin
      issue(OP_LOAD, l2_addr(word_sel[i]), '0);
    end

    check_atomic(OP_SWAP, 8'h10, 32'h1234_5678, 32'hCAFE_0001);
    check_atomic(OP_ADD,  8'h11, 32'hFFFF_FFFF, 32'h0000_0002);
    check_atomic(OP_AND,  8'h12, 32'hF0F0_F0F0, 32'h0FF0_FF00);
    check_atomic(OP_OR,   8'h13, 32'h0000_1200, 32'h8000_0034);
    check_atomic(OP_MAX,  8'h14, 32'hFFFF_FF00, 32'h0000_0005);
    check_atomic(OP_MAX,  8'h15, 32'hFFFF_FFFE, 32'h8000_0000);
    check_atomic(OP_MIN,  8'h16, 32'h0000_0005, 32'hFFFF_FF00);
    check_atomic(OP_MIN,  8'h17, 32'h8000_0000, 32'hFFFF_FFFE);
    // random atomics crowding a few words
    for (int i = 0; i < 24; i++) begin
      issue(amo_op_e'(3'(2 + $urandom % 6)), l2_addr(L2_IDX_W'($urandom % 4)), $urandom);
    end

    issue(OP_STORE, PERIPH_BASE + REG_FETCH_EN, 32'hFFFF_FFA5);
    issue(OP_LOAD,  PERIPH_BASE + REG_FETCH_EN, '0);
    issue(OP_OR,    PERIPH_BASE + REG_FETCH_EN, 32'h0000_0008);
    issue(OP_LOAD,  PERIPH_BASE + REG_EOC, '0);
    issue(OP_LOAD,  PERIPH_BASE + REG_BUSY, '0);

    // illegal requests, each followed by reads that prove nothing changed
    issue(OP_STORE, L2_BASE + 32'h12, 32'hDEAD_BEEF);
    issue(OP_LOAD,  L2_BASE + 32'h10, '0);
    issue(OP_LOAD,  32'h0000_1000, '0);
    issue(OP_STORE, L2_BASE + L2_WORDS * 4, 32'h0000_0001);
    issue(OP_LOAD,  L2_BASE, '0);
    issue(OP_LOAD,  PERIPH_BASE + 32'hC, '0);
    issue(OP_STORE, PERIPH_BASE + REG_EOC, 32'h0000_000F);
    issue(OP_SWAP,  PERIPH_BASE + REG_BUSY, 32'h0000_000F);
    issue(OP_ADD,   PERIPH_BASE + 32'h2, 32'h0000_0001);
    issue(OP_LOAD,  PERIPH_BASE + REG_FETCH_EN, '0);
    idle(1);

    drain_cycles = 0;
    while (exp_q.size() != 0 && drain_cycles < DRAIN_LIMIT) begin
      @(posedge clk_i);
      drain_cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d request(s) never got a response", exp_q.size());
      abort_run();
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== pulp_soc.f ====
rtl/pulp_soc_pkg.sv
rtl/soc_addr_decode.sv
rtl/l2_atomics_exec.sv
rtl/cluster_ctrl_periph.sv
rtl/soc_resp_merge.sv
rtl/pulp_soc.sv
verification/pulp_soc_sva.sv
verification/tb_pulp_soc.sv

// ==== Bender.yml ====
package:
  name: pulp_soc

sources:
  - files:
      - rtl/pulp_soc_pkg.sv
      - rtl/soc_addr_decode.sv
      - rtl/l2_atomics_exec.sv
      - rtl/cluster_ctrl_periph.sv
      - rtl/soc_resp_merge.sv
      - rtl/pulp_soc.sv
  - target: simulation
    files:
      - verification/pulp_soc_sva.sv
      - verification/tb_pulp_soc.sv
